/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_boot_fetch
FILELIST  = build.f
RUNFLAGS  = +verilator+error+limit+100
SIM_LOG   = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUNFLAGS) | tee $(SIM_LOG)
	grep -q "^sim passed$$" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

/* boot_fetch_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module boot_fetch_chk
    import rv_isa_pkg::*, boot_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               start,
    input  wire logic               we,
    input  wire logic [addr_w-1:0]  waddr,
    input  wire logic [xlen-1:0]    wdata,
    input  wire logic               load_done,
    input  wire logic               instr_valid,
    input  wire logic [addr_w-1:0]  pc,
    input  wire logic [xlen-1:0]    instr,
    input  wire op_class_t          op_class,
    input  wire logic [4:0]         rd,
    input  wire logic [xlen-1:0]    imm,
    input  wire logic               halt
);

    // failure count read by the testbench
    int unsigned       err_cnt = 0;
    // writes seen in the current load
    logic [4:0]        wr_idx;
    logic              done_seen;
    // next pc the fetch stream should show
    logic [addr_w-1:0] exp_pc;
    // image word that the expected pc points at
    logic [xlen-1:0]   exp_word;

    // image word at a byte address or zero past the end
    function automatic logic [xlen-1:0] image_word(input logic [addr_w-1:0] a);
        if (a < addr_w'(boot_len * 4)) begin
            return boot_image[a[6:2]];
        end else begin
            return '0;
        end
    endfunction

    function automatic op_class_t ref_class(input logic [xlen-1:0] w);
        case (w[6:0])
            op_reg:           return cls_alu;
            op_imm:           return cls_imm;
            op_load:          return cls_load;
            op_store:         return cls_store;
            op_branch:        return cls_branch;
            op_jal:           return cls_jal;
            op_jalr:          return cls_jalr;
            op_lui, op_auipc: return cls_upper;
            op_system:        return cls_system;
            default:          return cls_illegal;
        endcase
    endfunction

    // immediate per the rv32i encoding tables
    function automatic logic [xlen-1:0] ref_imm(input logic [xlen-1:0] w);
        case (w[6:0])
            op_imm, op_load, op_jalr, op_system: return {{20{w[31]}}, w[31:20]};
            op_store:         return {{20{w[31]}}, w[31:25], w[11:7]};
            op_branch:        return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            op_lui, op_auipc: return {w[31:12], 12'b0};
            op_jal:           return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:          return '0;
        endcase
    endfunction

    function automatic logic [4:0] ref_rd(input logic [xlen-1:0] w);
        if (w[6:0] == op_store || w[6:0] == op_branch || w[6:0] == op_system) begin
            return 5'd0;
        end else begin
            return w[11:7];
        end
    endfunction

    task automatic raise_error(input string msg);
        err_cnt = err_cnt + 1;
        $error("%s", msg);
    endtask

    assign exp_word = image_word(exp_pc);

    // reference model of load count and expected pc
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_idx    <= '0;
            done_seen <= 1'b0;
            exp_pc    <= '0;
        end else begin
            if (we) begin
                wr_idx <= wr_idx + 5'd1;
            end
            if (load_done) begin
                done_seen <= 1'b1;
            end
            // only jal redirects and all else falls through
            if (instr_valid) begin
                exp_pc <= (exp_word[6:0] == op_jal) ? exp_pc + ref_imm(exp_word)
                                                    : exp_pc + 32'd4;
            end
        end
    end

    a_reset: assert property (@(posedge clk) rst && $past(rst) |-> !we && !instr_valid && !halt)
        else raise_error("write, valid or halt active during reset");

    // load burst
    a_start: assert property (@(posedge clk) disable iff (rst) start && !we |=> we)
        else raise_error("write burst did not begin the cycle after start");
    a_waddr: assert property (@(posedge clk) disable iff (rst)
        we |-> waddr == (addr_w'(wr_idx) << 2))
        else raise_error($sformatf("Fail %0t waddr expected %h got %h",
            $time, addr_w'(wr_idx) << 2, waddr));
    a_wdata: assert property (@(posedge clk) disable iff (rst)
        we |-> wdata == image_word(addr_w'(wr_idx) << 2))
        else raise_error($sformatf("Fail %0t wdata expected %h got %h",
            $time, image_word(addr_w'(wr_idx) << 2), wdata));
    a_wrun: assert property (@(posedge clk) disable iff (rst)
        we && wr_idx < 5'(boot_len - 1) |=> we)
        else raise_error("write burst broke off before the last image word");
    a_done: assert property (@(posedge clk) disable iff (rst)
        we && wr_idx == 5'(boot_len - 1) |=> load_done && !we)
        else raise_error("load did not end with load_done after the last write");
    a_done_once: assert property (@(posedge clk) disable iff (rst)
        load_done |-> !done_seen && wr_idx == 5'(boot_len))
        else raise_error("load_done pulsed more than once or out of place");

    // fetch stream
    a_word: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> instr == image_word(pc))
        else raise_error($sformatf("Fail %0t instr expected %h got %h",
            $time, image_word(pc), instr));
    a_pc: assert property (@(posedge clk) disable iff (rst) instr_valid |-> pc == exp_pc)
        else raise_error($sformatf("Fail %0t pc expected %h got %h", $time, exp_pc, pc));

    // decode fields
    a_class: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> op_class == ref_class(instr))
        else raise_error($sformatf("Fail %0t op_class expected %0d got %0d",
            $time, ref_class(instr), op_class));
    a_rd: assert property (@(posedge clk) disable iff (rst) instr_valid |-> rd == ref_rd(instr))
        else raise_error($sformatf("Fail %0t rd expected %0d got %0d",
            $time, ref_rd(instr), rd));
    a_imm: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> imm == ref_imm(instr))
        else raise_error($sformatf("Fail %0t imm expected %h got %h",
            $time, ref_imm(instr), imm));

    // halt on the return
    a_jalr: assert property (@(posedge clk) disable iff (rst)
        instr_valid && instr[6:0] == op_jalr |=> halt)
        else raise_error("halt did not follow a valid jalr");
    a_halt_src: assert property (@(posedge clk) disable iff (rst)
        $rose(halt) |-> $past(instr_valid && instr[6:0] == op_jalr && pc == 32'd64))
        else raise_error("halt rose without the return at byte 64");
    a_halt_hold: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
        else raise_error("halt dropped before reset");
    a_halt_quiet: assert property (@(posedge clk) disable iff (rst) halt |-> !instr_valid)
        else raise_error("instr_valid seen after halt");

endmodule

bind boot_fetch_top boot_fetch_chk chk_i (.*);

`default_nettype wire

/* boot_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module boot_fetch_top
    import rv_isa_pkg::*, boot_pkg::*;
#(
    // must hold the whole boot image
    parameter int MEM_WORDS = 32
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               start,
    output logic                    we,
    output logic [addr_w-1:0]       waddr,
    output logic [xlen-1:0]         wdata,
    output logic                    load_done,
    output logic                    instr_valid,
    output logic [addr_w-1:0]       pc,
    output logic [xlen-1:0]         instr,
    output op_class_t               op_class,
    output logic [4:0]              rd,
    output logic [xlen-1:0]         imm,
    output logic                    halt
);

    // read side between control, memory and decoder
    logic              re;
    logic [addr_w-1:0] raddr;
    logic [xlen-1:0]   rdata;
    logic              fetch_valid;
    logic [addr_w-1:0] fetch_pc;
    // decoder feedback for redirect and halt
    logic              is_jal;
    logic              is_jalr;

    program_loader loader_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .we        (we),
        .waddr     (waddr),
        .wdata     (wdata),
        .load_done (load_done)
    );

    instr_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) mem_i (
        .clk   (clk),
        .we    (we),
        .waddr (waddr),
        .wdata (wdata),
        .re    (re),
        .raddr (raddr),
        .rdata (rdata)
    );

    // decoded pc and valid double as the redirect source
    fetch_ctrl #(
        .MEM_WORDS (MEM_WORDS)
    ) ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .load_done   (load_done),
        .is_jal      (is_jal),
        .is_jalr     (is_jalr),
        .dec_valid   (instr_valid),
        .dec_pc      (pc),
        .imm         (imm),
        .re          (re),
        .raddr       (raddr),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .halt        (halt)
    );

    instr_decode decode_i (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .rdata       (rdata),
        .instr_valid (instr_valid),
        .pc          (pc),
        .instr       (instr),
        .op_class    (op_class),
        .rd          (rd),
        .imm         (imm),
        .is_jal      (is_jal),
        .is_jalr     (is_jalr)
    );

endmodule

`default_nettype wire

/* boot_pkg.sv */
`default_nettype none

package boot_pkg;

    import rv_isa_pkg::*;

    // byte address width of the fetch side
    localparam int addr_w = 32;

    // words in the boot program
    localparam int boot_len = 17;

    // small leaf function, ends in ret
    localparam logic [xlen-1:0] boot_image [boot_len] = '{
        32'hfe010113, // addi sp, sp, -32
        32'h00112e23, // sw   ra, 28(sp)
        32'h00812c23, // sw   s0, 24(sp)
        32'h02010413, // addi s0, sp, 32
        32'h00a00793, // addi a5, zero, 10
        32'hfef42623, // sw   a5, -20(s0)
        32'hfec42703, // lw   a4, -20(s0)
        32'h00a00793, // addi a5, zero, 10
        32'h00f71663, // bne  a4, a5, +12
        32'h00100793, // addi a5, zero, 1
        32'h0080006f, // jal  zero, +8
        32'h00000793, // addi a5, zero, 0 (skipped by the jal)
        32'h00078513, // addi a0, a5, 0
        32'h01c12083, // lw   ra, 28(sp)
        32'h01812403, // lw   s0, 24(sp)
        32'h02010113, // addi sp, sp, 32
        32'h00008067  // jalr zero, 0(ra), the return
    };

endpackage

`default_nettype wire

/* build.f */
rv_isa_pkg.sv
boot_pkg.sv
program_loader.sv
instr_mem.sv
fetch_ctrl.sv
instr_decode.sv
boot_fetch_top.sv
boot_fetch_chk.sv
tb_boot_fetch.sv

/* fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl
    import rv_isa_pkg::*, boot_pkg::*;
#(
    parameter int MEM_WORDS = 32
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               load_done,
    input  wire logic               is_jal,
    input  wire logic               is_jalr,
    input  wire logic               dec_valid,
    input  wire logic [addr_w-1:0]  dec_pc,
    input  wire logic [xlen-1:0]    imm,
    output logic                    re,
    output logic [addr_w-1:0]       raddr,
    output logic                    fetch_valid,
    output logic [addr_w-1:0]       fetch_pc,
    output logic                    halt
);

    // fsm encoding
    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_fetch  = 2'd1;
    localparam logic [1:0] st_halted = 2'd2;

    // first byte address past the memory
    localparam logic [addr_w-1:0] pc_end = addr_w'(MEM_WORDS * 4);

    logic [1:0]        state;
    // issue slot, the pc being read this cycle
    logic [addr_w-1:0] pc;
    // data slot, the read whose word is on rdata now
    logic              data_valid;
    logic [addr_w-1:0] data_pc;

    logic jal_take;
    logic jalr_take;
    logic squash;
    logic in_range;

    // control transfers only act while fetching
    assign jal_take  = dec_valid && is_jal && (state == st_fetch);
    assign jalr_take = dec_valid && is_jalr && (state == st_fetch);
    // kills both younger fetches
    assign squash    = jal_take || jalr_take;
    assign in_range  = (pc < pc_end);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            pc         <= '0;
            data_valid <= 1'b0;
        end else begin
            // issue slot moves into the data slot unless squashed
            data_valid <= re && !squash;
            case (state)
                st_idle: begin
                    if (load_done) begin
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (jalr_take) begin
                        // return taken as the end of the program
                        state <= st_halted;
                    end else if (jal_take) begin
                        pc <= dec_pc + imm[addr_w-1:0];
                    end else if (!in_range) begin
                        state <= st_halted;
                    end else begin
                        pc <= pc + 32'd4;
                    end
                end
                default: begin
                    // halted until reset
                    state <= st_halted;
                end
            endcase
        end
    end

    // pc that goes with rdata
    always_ff @(posedge clk) begin
        data_pc <= pc;
    end

    assign re          = (state == st_fetch) && in_range;
    assign raddr       = pc;
    assign fetch_valid = data_valid && !squash;
    assign fetch_pc    = data_pc;
    assign halt        = (state == st_halted);

endmodule

`default_nettype wire

/* instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode
    import rv_isa_pkg::*, boot_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               fetch_valid,
    input  wire logic [addr_w-1:0]  fetch_pc,
    input  wire logic [xlen-1:0]    rdata,
    output logic                    instr_valid,
    output logic [addr_w-1:0]       pc,
    output logic [xlen-1:0]         instr,
    output op_class_t               op_class,
    output logic [4:0]              rd,
    output logic [xlen-1:0]         imm,
    output logic                    is_jal,
    output logic                    is_jalr
);

    instr_u    word;
    op_class_t cls;
    logic [xlen-1:0] imm_d;
    logic [4:0]      rd_d;

    assign word = rdata;

    // opcode to class, then pick the immediate layout
    always_comb begin
        cls   = cls_illegal;
        imm_d = '0;
        case (word.i.opcode)
            op_reg:    cls = cls_alu;
            op_imm:    cls = cls_imm;
            op_load:   cls = cls_load;
            op_store:  cls = cls_store;
            op_branch: cls = cls_branch;
            op_jal:    cls = cls_jal;
            op_jalr:   cls = cls_jalr;
            op_lui:    cls = cls_upper;
            op_auipc:  cls = cls_upper;
            op_system: cls = cls_system;
            default:   cls = cls_illegal;
        endcase
        case (cls)
            // I format
            cls_imm, cls_load, cls_jalr, cls_system: begin
                imm_d = {{20{word.i.imm12[11]}}, word.i.imm12};
            end
            // S format, low bits sit in the rd slot
            cls_store: begin
                imm_d = {{20{word.i.imm12[11]}}, word.i.imm12[11:5], word.i.rd};
            end
            // B format, bit 11 hides in rd[0]
            cls_branch: begin
                imm_d = {{20{word.i.imm12[11]}}, word.i.rd[0], word.i.imm12[10:5],
                         word.i.rd[4:1], 1'b0};
            end
            // U format, top 20 bits
            cls_upper: begin
                imm_d = {word.i.imm12, word.i.rs1, word.i.funct3, 12'b0};
            end
            // J format from the other view
            cls_jal: begin
                imm_d = {{12{word.j.imm20}}, word.j.imm19_12, word.j.imm11,
                         word.j.imm10_1, 1'b0};
            end
            default: imm_d = '0;
        endcase
        // no destination for these
        if (cls == cls_store || cls == cls_branch || cls == cls_system) begin
            rd_d = 5'd0;
        end else begin
            rd_d = word.i.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= fetch_valid;
        end
    end

    // payload held while no live fetch arrives
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            pc       <= fetch_pc;
            instr    <= rdata;
            op_class <= cls;
            rd       <= rd_d;
            imm      <= imm_d;
            is_jal   <= (cls == cls_jal);
            is_jalr  <= (cls == cls_jalr);
        end
    end

endmodule

`default_nettype wire

/* instr_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_mem
    import rv_isa_pkg::*, boot_pkg::*;
#(
    parameter int MEM_WORDS = 32
) (
    input  wire logic               clk,
    input  wire logic               we,
    input  wire logic [addr_w-1:0]  waddr,
    input  wire logic [xlen-1:0]    wdata,
    input  wire logic               re,
    input  wire logic [addr_w-1:0]  raddr,
    output logic [xlen-1:0]         rdata
);

    // word index bits actually stored
    localparam int idx_w = $clog2(MEM_WORDS);

    logic [xlen-1:0] mem [MEM_WORDS];

    // addresses are byte based, low two bits dropped
    logic wr_hit;
    logic rd_hit;

    assign wr_hit = (waddr[addr_w-1:2] < (addr_w - 2)'(MEM_WORDS));
    assign rd_hit = (raddr[addr_w-1:2] < (addr_w - 2)'(MEM_WORDS));

    // write port, out of range writes dropped
    always_ff @(posedge clk) begin
        if (we && wr_hit) begin
            mem[waddr[idx_w+1:2]] <= wdata;
        end
    end

    // registered read, zero past the end
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= rd_hit ? mem[raddr[idx_w+1:2]] : '0;
        end
    end

endmodule

`default_nettype wire

/* program_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module program_loader
    import rv_isa_pkg::*, boot_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              start,
    output logic                   we,
    output logic [addr_w-1:0]      waddr,
    output logic [xlen-1:0]        wdata,
    output logic                   load_done
);

    // enough bits to count through the image
    localparam int idx_w = $clog2(boot_len);

    // word index into the image
    logic [idx_w-1:0] idx;
    // high while the copy runs
    logic             busy;
    // current word is the final one
    logic             last;

    assign last = (idx == idx_w'(boot_len - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            idx       <= '0;
            load_done <= 1'b0;
        end else begin
            // done is a single cycle strobe
            load_done <= 1'b0;
            if (busy) begin
                if (last) begin
                    busy      <= 1'b0;
                    idx       <= '0;
                    load_done <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                end
            end else if (start) begin
                // start only counts when idle
                busy <= 1'b1;
                idx  <= '0;
            end
        end
    end

    // one word per busy cycle
    assign we = busy;

    // byte address is index times four
    assign waddr = addr_w'({idx, 2'b00});

    // image word at the current index
    assign wdata = boot_image[idx];

endmodule

`default_nettype wire

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // data path width
    localparam int xlen = 32;

    // major opcodes, bits [6:0] of every instruction
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_system = 7'b1110011;

    // coarse instruction class seen by the front end
    typedef enum logic [3:0] {
        cls_alu,
        cls_imm,
        cls_load,
        cls_store,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_upper,
        cls_system,
        cls_illegal
    } op_class_t;

    // one word, two field layouts
    typedef union packed {
        // I layout, also the raw bit positions for S, B and U
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        // J layout, scrambled 20-bit offset
        struct packed {
            logic        imm20;
            logic [9:0]  imm10_1;
            logic        imm11;
            logic [7:0]  imm19_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } j;
    } instr_u;

endpackage

`default_nettype wire

/* tb_boot_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_boot_fetch
    import rv_isa_pkg::*, boot_pkg::*;
();

    localparam int clk_period = 10;
    // load, fetch and the idle tail fit well inside this
    localparam int watchdog_cycles = boot_len * 4 + 50;

    logic              clk;
    logic              rst;
    logic              start;
    logic              we;
    logic [addr_w-1:0] waddr;
    logic [xlen-1:0]   wdata;
    logic              load_done;
    logic              instr_valid;
    logic [addr_w-1:0] pc;
    logic [xlen-1:0]   instr;
    op_class_t         op_class;
    logic [4:0]        rd;
    logic [xlen-1:0]   imm;
    logic              halt;

    boot_fetch_top #(
        .MEM_WORDS (32)
    ) dut_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .we          (we),
        .waddr       (waddr),
        .wdata       (wdata),
        .load_done   (load_done),
        .instr_valid (instr_valid),
        .pc          (pc),
        .instr       (instr),
        .op_class    (op_class),
        .rd          (rd),
        .imm         (imm),
        .halt        (halt)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // one cycle strobe, set up on the falling edge
    task automatic pulse_start();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_for_halt();
        while (!halt) begin
            @(negedge clk);
        end
    endtask

    // any checker assertion ends the run
    initial begin
        wait (dut_i.chk_i.err_cnt != 0);
        $display("sim failed");
        $fatal(1, "checker raised an assertion failure");
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("sim failed");
        $fatal(1, "timeout, halt not reached within %0d cycles", watchdog_cycles);
    end

    initial begin
        rst   = 1'b1;
        start = 1'b0;
        // two rising edges under reset
        idle_cycles(2);
        rst = 1'b0;
        idle_cycles(1);
        pulse_start();
        // lands mid load, loader must ignore it
        idle_cycles(5);
        pulse_start();
        wait_for_halt();
        // tail lets the halt checks run a few cycles
        idle_cycles(5);
        if (dut_i.chk_i.err_cnt == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "%0d assertion failures reported", dut_i.chk_i.err_cnt);
        end
    end

endmodule

`default_nettype wire
